/* line_buffer_pkg.sv */
// line buffer package: window sizes, vector types and border mode encoding
`default_nettype none

package line_buffer_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int WIN_LINES       = 5;
	// counted from the newest row
	localparam int CENTER_ROW      = 2;
	localparam int MEM_LINES       = 4;
	localparam int PIXEL_BITS      = 8;
	localparam int MAX_LINE_PIXELS = 64;
	localparam int COL_BITS        = 6;
	localparam int SEL_BITS        = 2;
	localparam int POS_BITS        = 3;
	localparam int PIPE_LATENCY    = 7;

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------
	typedef logic [PIXEL_BITS-1:0] pixel_t;
	typedef logic [COL_BITS-1:0]   col_addr_t;
	typedef logic [SEL_BITS-1:0]   line_sel_t;
	typedef logic [POS_BITS-1:0]   row_pos_t;
	typedef logic [WIN_LINES-1:0]  row_flags_t;

	typedef enum logic [1:0] {
		REPLICATE   = 2'd0,
		CONSTANT    = 2'd1,
		REFLECT_101 = 2'd2
	} border_mode_t;

	// row position that selects the border value
	localparam row_pos_t BORDER_POS = row_pos_t'(WIN_LINES);

endpackage

`default_nettype wire

/* img_ctrl_if.sv */
// image control interface: framing flags and valid between pipeline sections
`timescale 1ns/1ps
`default_nettype none

interface img_ctrl_if;

	logic line_first;
	logic line_last;
	logic pixel_first;
	logic pixel_last;
	logic de;
	logic valid;

	modport src (
		output line_first,
		output line_last,
		output pixel_first,
		output pixel_last,
		output de,
		output valid
	);

	modport dst (
		input line_first,
		input line_last,
		input pixel_first,
		input pixel_last,
		input de,
		input valid
	);

endinterface

`default_nettype wire

/* line_ram.sv */
// line ram: single-port read-first memory of one image line, two-cycle read
`timescale 1ns/1ps
`default_nettype none

module line_ram
	import line_buffer_pkg::*;
(
	input  logic      clk,
	input  logic      we,
	input  col_addr_t addr,
	input  pixel_t    wdata,
	output pixel_t    rdata
);

	pixel_t mem [MAX_LINE_PIXELS];
	pixel_t rd_q;

	// read-first: old contents leave before the write lands
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rd_q <= mem[addr];
	end

	// output register
	always_ff @(posedge clk) begin
		rdata <= rd_q;
	end

endmodule

`default_nettype wire

/* line_store.sv */
// line store for stages 0 to 3 with rotating line memories and per-row framing flags
`timescale 1ns/1ps
`default_nettype none

module line_store
	import line_buffer_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       s_line_first,
	input  logic       s_line_last,
	input  logic       s_pixel_first,
	input  logic       s_pixel_last,
	input  logic       s_de,
	input  logic       s_valid,
	input  pixel_t     s_data,
	output pixel_t     column [WIN_LINES],
	output row_flags_t row_line_first,
	output row_flags_t row_line_last,
	img_ctrl_if.src    ctrl
);

	logic [MEM_LINES-1:0] st0_we;
	col_addr_t            st0_addr;
	logic                 st0_line_first;
	logic                 st0_line_last;
	logic                 st0_pixel_first;
	logic                 st0_pixel_last;
	logic                 st0_de;
	logic                 st0_valid;
	pixel_t               st0_data;

	logic                 st1_line_first;
	logic                 st1_line_last;
	logic                 st1_pixel_first;
	logic                 st1_pixel_last;
	logic                 st1_de;
	logic                 st1_valid;
	pixel_t               st1_data;

	line_sel_t            st2_sel;
	logic                 st2_line_first;
	logic                 st2_line_last;
	logic                 st2_pixel_first;
	logic                 st2_pixel_last;
	logic                 st2_de;
	logic                 st2_valid;
	pixel_t               st2_data;

	row_flags_t           row_de;
	logic                 st3_pixel_first;
	logic                 st3_pixel_last;
	logic                 st3_valid;

	pixel_t               mem_rdata [MEM_LINES];

	// ------------------------------------------------------------------------
	// line memories
	// ------------------------------------------------------------------------
	for (genvar i = 0; i < MEM_LINES; i++) begin : g_mem
		line_ram i_line_ram (
			.clk   (clk),
			.we    (st0_we[i] & st0_valid),
			.addr  (st0_addr),
			.wdata (st0_data),
			.rdata (mem_rdata[i])
		);
	end

	// ------------------------------------------------------------------------
	// control pipeline
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			st0_we          <= {1'b1, {(MEM_LINES-1){1'b0}}};
			st0_addr        <= '0;
			st0_line_first  <= 1'b0;
			st0_line_last   <= 1'b0;
			st0_pixel_first <= 1'b0;
			st0_pixel_last  <= 1'b0;
			st0_de          <= 1'b0;
			st0_valid       <= 1'b0;
			st1_line_first  <= 1'b0;
			st1_line_last   <= 1'b0;
			st1_pixel_first <= 1'b0;
			st1_pixel_last  <= 1'b0;
			st1_de          <= 1'b0;
			st1_valid       <= 1'b0;
			st2_sel         <= '0;
			st2_line_first  <= 1'b0;
			st2_line_last   <= 1'b0;
			st2_pixel_first <= 1'b0;
			st2_pixel_last  <= 1'b0;
			st2_de          <= 1'b0;
			st2_valid       <= 1'b0;
			row_line_first  <= '0;
			row_line_last   <= '0;
			row_de          <= '0;
			st3_pixel_first <= 1'b0;
			st3_pixel_last  <= 1'b0;
			st3_valid       <= 1'b0;
		end else begin
			// stage 0 writes the newest line over the oldest memory
			if (s_valid && s_pixel_first) begin
				st0_we   <= {st0_we[0], st0_we[MEM_LINES-1:1]};
				st0_addr <= '0;
			end else if (s_valid) begin
				st0_addr <= st0_addr + col_addr_t'(1);
			end
			st0_line_first  <= s_line_first & s_valid;
			st0_line_last   <= s_line_last & s_valid;
			st0_pixel_first <= s_pixel_first & s_valid;
			st0_pixel_last  <= s_pixel_last & s_valid;
			st0_de          <= s_de & s_valid;
			st0_valid       <= s_valid;

			// stage 1
			st1_line_first  <= st0_line_first;
			st1_line_last   <= st0_line_last;
			st1_pixel_first <= st0_pixel_first;
			st1_pixel_last  <= st0_pixel_last;
			st1_de          <= st0_de;
			st1_valid       <= st0_valid;

			// stage 2 counts the read select along with the write rotation
			if (st1_valid && st1_pixel_first) begin
				st2_sel <= st2_sel - line_sel_t'(1);
			end
			st2_line_first  <= st1_line_first;
			st2_line_last   <= st1_line_last;
			st2_pixel_first <= st1_pixel_first;
			st2_pixel_last  <= st1_pixel_last;
			st2_de          <= st1_de;
			st2_valid       <= st1_valid;

			// stage 3 ages the row flags by one line at each line start
			if (st2_valid) begin
				if (st2_pixel_first) begin
					row_line_first <= {row_line_first[WIN_LINES-2:0], st2_line_first};
					row_line_last  <= {row_line_last[WIN_LINES-2:0], st2_line_last};
					row_de         <= {row_de[WIN_LINES-2:0], st2_de};
				end else begin
					row_line_first[0] <= row_line_first[0] | st2_line_first;
					row_line_last[0]  <= row_line_last[0] | st2_line_last;
					row_de[0]         <= row_de[0] | st2_de;
				end
			end
			st3_pixel_first <= st2_pixel_first;
			st3_pixel_last  <= st2_pixel_last;
			st3_valid       <= st2_valid;
		end
	end

	// ------------------------------------------------------------------------
	// pixel path
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		st0_data  <= s_data;
		st1_data  <= st0_data;
		st2_data  <= st1_data;
		column[0] <= st2_data;
		// memories in age order with row 1 the newest stored line
		for (int j = 0; j < MEM_LINES; j++) begin
			column[j+1] <= mem_rdata[line_sel_t'(line_sel_t'(j) + st2_sel)];
		end
	end

	assign ctrl.line_first  = row_line_first[CENTER_ROW] & st3_valid;
	assign ctrl.line_last   = row_line_last[CENTER_ROW] & st3_valid;
	assign ctrl.pixel_first = st3_pixel_first;
	assign ctrl.pixel_last  = st3_pixel_last;
	assign ctrl.de          = row_de[CENTER_ROW] & st3_valid;
	assign ctrl.valid       = st3_valid;

endmodule

`default_nettype wire

/* border_locator.sv */
// border locator: stages 4 and 5, frame edge search and row position map
`timescale 1ns/1ps
`default_nettype none

module border_locator
	import line_buffer_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  border_mode_t border_mode,
	input  pixel_t       column [WIN_LINES],
	input  row_flags_t   row_line_first,
	input  row_flags_t   row_line_last,
	img_ctrl_if.dst      ctrl_in,
	img_ctrl_if.src      ctrl_out,
	output pixel_t       column_out [WIN_LINES],
	output row_pos_t     pos_map [WIN_LINES]
);

	row_pos_t search_first;
	row_pos_t search_last;
	logic     first_found;
	logic     last_found;
	row_pos_t pos_next [WIN_LINES];

	logic     st4_line_first;
	logic     st4_line_last;
	logic     st4_pixel_first;
	logic     st4_pixel_last;
	logic     st4_de;
	logic     st4_valid;
	pixel_t   st4_column [WIN_LINES];
	row_pos_t st4_pos_first;
	row_pos_t st4_pos_last;

	// ------------------------------------------------------------------------
	// edge search, nearest edge to the centre wins
	// ------------------------------------------------------------------------
	always_comb begin
		search_first = row_pos_t'(WIN_LINES - 1);
		first_found  = 1'b0;
		for (int y = CENTER_ROW; y < WIN_LINES; y++) begin
			if (!first_found && row_line_first[y]) begin
				search_first = row_pos_t'(y);
				first_found  = 1'b1;
			end
		end
		search_last = '0;
		last_found  = 1'b0;
		for (int y = CENTER_ROW; y >= 0; y--) begin
			if (!last_found && row_line_last[y]) begin
				search_last = row_pos_t'(y);
				last_found  = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// position map
	// ------------------------------------------------------------------------
	always_comb begin
		for (int y = 0; y < WIN_LINES; y++) begin
			pos_next[y] = row_pos_t'(y);
			// older rows above the first line
			if (y > CENTER_ROW && y > int'(st4_pos_first)) begin
				case (border_mode)
					REPLICATE:   pos_next[y] = st4_pos_first;
					REFLECT_101: pos_next[y] = row_pos_t'(2 * int'(st4_pos_first) - y);
					default:     pos_next[y] = BORDER_POS;
				endcase
			end
			// newer rows below the last line
			if (y < CENTER_ROW && y < int'(st4_pos_last)) begin
				case (border_mode)
					REPLICATE:   pos_next[y] = st4_pos_last;
					REFLECT_101: pos_next[y] = row_pos_t'(2 * int'(st4_pos_last) - y);
					default:     pos_next[y] = BORDER_POS;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			st4_line_first       <= 1'b0;
			st4_line_last        <= 1'b0;
			st4_pixel_first      <= 1'b0;
			st4_pixel_last       <= 1'b0;
			st4_de               <= 1'b0;
			st4_valid            <= 1'b0;
			ctrl_out.line_first  <= 1'b0;
			ctrl_out.line_last   <= 1'b0;
			ctrl_out.pixel_first <= 1'b0;
			ctrl_out.pixel_last  <= 1'b0;
			ctrl_out.de          <= 1'b0;
			ctrl_out.valid       <= 1'b0;
		end else begin
			st4_line_first       <= ctrl_in.line_first;
			st4_line_last        <= ctrl_in.line_last;
			st4_pixel_first      <= ctrl_in.pixel_first;
			st4_pixel_last       <= ctrl_in.pixel_last;
			st4_de               <= ctrl_in.de;
			st4_valid            <= ctrl_in.valid;
			ctrl_out.line_first  <= st4_line_first;
			ctrl_out.line_last   <= st4_line_last;
			ctrl_out.pixel_first <= st4_pixel_first;
			ctrl_out.pixel_last  <= st4_pixel_last;
			ctrl_out.de          <= st4_de;
			ctrl_out.valid       <= st4_valid;
		end
	end

	always_ff @(posedge clk) begin
		st4_column    <= column;
		st4_pos_first <= search_first;
		st4_pos_last  <= search_last;
		column_out    <= st4_column;
		pos_map       <= pos_next;
	end

endmodule

`default_nettype wire

/* border_mux.sv */
// border mux: stage 6, picks each output row and puts the oldest line first
`timescale 1ns/1ps
`default_nettype none

module border_mux
	import line_buffer_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  pixel_t   border_value,
	img_ctrl_if.dst  ctrl_in,
	input  pixel_t   column [WIN_LINES],
	input  row_pos_t pos_map [WIN_LINES],
	output logic     m_line_first,
	output logic     m_line_last,
	output logic     m_pixel_first,
	output logic     m_pixel_last,
	output logic     m_de,
	output logic     m_valid,
	output pixel_t   m_column [WIN_LINES]
);

	pixel_t picked [WIN_LINES];

	always_comb begin
		for (int y = 0; y < WIN_LINES; y++) begin
			if (pos_map[y] >= BORDER_POS) begin
				picked[y] = border_value;
			end else begin
				picked[y] = column[pos_map[y]];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			m_line_first  <= 1'b0;
			m_line_last   <= 1'b0;
			m_pixel_first <= 1'b0;
			m_pixel_last  <= 1'b0;
			m_de          <= 1'b0;
			m_valid       <= 1'b0;
		end else begin
			m_line_first  <= ctrl_in.line_first;
			m_line_last   <= ctrl_in.line_last;
			m_pixel_first <= ctrl_in.pixel_first;
			m_pixel_last  <= ctrl_in.pixel_last;
			m_de          <= ctrl_in.de;
			m_valid       <= ctrl_in.valid;
		end
	end

	// internal row 0 is the newest, output row 0 the oldest
	always_ff @(posedge clk) begin
		for (int y = 0; y < WIN_LINES; y++) begin
			m_column[y] <= picked[WIN_LINES-1-y];
		end
	end

endmodule

`default_nettype wire

/* line_buffer_top.sv */
// line buffer top: five-line vertical window over a valid-qualified pixel stream
`timescale 1ns/1ps
`default_nettype none

module line_buffer_top
	import line_buffer_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// input stream
	input  logic         s_line_first,
	input  logic         s_line_last,
	input  logic         s_pixel_first,
	input  logic         s_pixel_last,
	input  logic         s_de,
	input  logic         s_valid,
	input  pixel_t       s_data,

	// border control, held stable across a frame
	input  border_mode_t border_mode,
	input  pixel_t       border_value,

	// output column, row 0 oldest
	output logic         m_line_first,
	output logic         m_line_last,
	output logic         m_pixel_first,
	output logic         m_pixel_last,
	output logic         m_de,
	output logic         m_valid,
	output pixel_t       m_data [WIN_LINES]
);

	img_ctrl_if store_ctrl ();
	img_ctrl_if locate_ctrl ();

	pixel_t     store_column [WIN_LINES];
	row_flags_t row_line_first;
	row_flags_t row_line_last;
	pixel_t     locate_column [WIN_LINES];
	row_pos_t   pos_map [WIN_LINES];

	// ------------------------------------------------------------------------
	// stages 0 to 3
	// ------------------------------------------------------------------------
	line_store i_line_store (
		.clk            (clk),
		.reset          (reset),
		.s_line_first   (s_line_first),
		.s_line_last    (s_line_last),
		.s_pixel_first  (s_pixel_first),
		.s_pixel_last   (s_pixel_last),
		.s_de           (s_de),
		.s_valid        (s_valid),
		.s_data         (s_data),
		.column         (store_column),
		.row_line_first (row_line_first),
		.row_line_last  (row_line_last),
		.ctrl           (store_ctrl.src)
	);

	// ------------------------------------------------------------------------
	// stages 4 and 5
	// ------------------------------------------------------------------------
	border_locator i_border_locator (
		.clk            (clk),
		.reset          (reset),
		.border_mode    (border_mode),
		.column         (store_column),
		.row_line_first (row_line_first),
		.row_line_last  (row_line_last),
		.ctrl_in        (store_ctrl.dst),
		.ctrl_out       (locate_ctrl.src),
		.column_out     (locate_column),
		.pos_map        (pos_map)
	);

	// stage 6
	border_mux i_border_mux (
		.clk           (clk),
		.reset         (reset),
		.border_value  (border_value),
		.ctrl_in       (locate_ctrl.dst),
		.column        (locate_column),
		.pos_map       (pos_map),
		.m_line_first  (m_line_first),
		.m_line_last   (m_line_last),
		.m_pixel_first (m_pixel_first),
		.m_pixel_last  (m_pixel_last),
		.m_de          (m_de),
		.m_valid       (m_valid),
		.m_column      (m_data)
	);

endmodule

`default_nettype wire

/* line_buffer_assertions.sv */
// line buffer assertions: reset clearing, valid latency and flag qualification
`timescale 1ns/1ps
`default_nettype none

module line_buffer_assertions
	import line_buffer_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic s_valid,
	input logic m_line_first,
	input logic m_line_last,
	input logic m_pixel_first,
	input logic m_pixel_last,
	input logic m_de,
	input logic m_valid
);

	// outputs cleared one cycle after reset
	reset_clears_outputs: assert property (
		@(posedge clk) $past(reset) |-> !m_valid && !m_line_first && !m_line_last
			&& !m_pixel_first && !m_pixel_last && !m_de
	) else $error("stream outputs not low in the cycle after reset");

	// valid passes through the whole pipeline unchanged
	valid_latency: assert property (
		@(posedge clk) disable iff (reset) m_valid == $past(s_valid, PIPE_LATENCY)
	) else $error("m_valid does not follow s_valid by the pipeline latency");

	flags_need_valid: assert property (
		@(posedge clk) disable iff (reset) (m_pixel_first || m_de) |-> m_valid
	) else $error("m_pixel_first or m_de high without m_valid");

endmodule

`default_nettype wire

/* tb_line_buffer.sv */
// line buffer testbench: directed frames checked against a column reference model
`timescale 1ns/1ps
`default_nettype none

module tb_line_buffer
	import line_buffer_pkg::*;
();

	// upper bound, gapped frame counted at four cycles per pixel
	localparam int STIM_CYCLES    = 36 + 8 * 8 * 2 + 10 * 6 + 64 * 7 * 4 + 4 * 20;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

	logic         clk;
	logic         reset;
	logic         s_line_first;
	logic         s_line_last;
	logic         s_pixel_first;
	logic         s_pixel_last;
	logic         s_de;
	logic         s_valid;
	pixel_t       s_data;
	border_mode_t border_mode;
	pixel_t       border_value;
	logic         m_line_first;
	logic         m_line_last;
	logic         m_pixel_first;
	logic         m_pixel_last;
	logic         m_de;
	logic         m_valid;
	pixel_t       m_data [WIN_LINES];

	// reference frame and bookkeeping
	pixel_t       frame_pix [8][MAX_LINE_PIXELS];
	int           frame_w = 1;
	int           frame_h = 1;
	int           count_base = 0;
	int           seen_count = 0;
	int           cycle_count = 0;
	logic [31:0]  rng_state = 32'he335_8bb5;
	logic         run_finished = 1'b0;

	line_buffer_top i_line_buffer_top (
		.clk           (clk),
		.reset         (reset),
		.s_line_first  (s_line_first),
		.s_line_last   (s_line_last),
		.s_pixel_first (s_pixel_first),
		.s_pixel_last  (s_pixel_last),
		.s_de          (s_de),
		.s_valid       (s_valid),
		.s_data        (s_data),
		.border_mode   (border_mode),
		.border_value  (border_value),
		.m_line_first  (m_line_first),
		.m_line_last   (m_line_last),
		.m_pixel_first (m_pixel_first),
		.m_pixel_last  (m_pixel_last),
		.m_de          (m_de),
		.m_valid       (m_valid),
		.m_data        (m_data)
	);

	bind line_buffer_top line_buffer_assertions i_line_buffer_assertions (
		.clk           (clk),
		.reset         (reset),
		.s_valid       (s_valid),
		.m_line_first  (m_line_first),
		.m_line_last   (m_line_last),
		.m_pixel_first (m_pixel_first),
		.m_pixel_last  (m_pixel_last),
		.m_de          (m_de),
		.m_valid       (m_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// rows outside the frame follow the border mode
	function automatic logic [31:0] model_pixel(input int centre, input int x, input int offset);
		int src;
		src = centre + offset;
		if (src < 0 || src >= frame_h) begin
			if (border_mode == CONSTANT) begin
				return 32'(border_value);
			end else if (border_mode == REPLICATE) begin
				src = (src < 0) ? 0 : frame_h - 1;
			end else begin
				src = (src < 0) ? -src : 2 * (frame_h - 1) - src;
			end
		end
		return 32'(frame_pix[src][x]);
	endfunction

	task automatic check_column(input int line, input int x);
		int r;
		for (r = 0; r < WIN_LINES; r++) begin
			check_value($sformatf("m_data[%0d] at line %0d x %0d", r, line, x),
				32'(m_data[r]), model_pixel(line, x, r - CENTER_ROW));
		end
		check_value("m_line_first", 32'(m_line_first), 32'(line == 0));
		check_value("m_line_last", 32'(m_line_last), 32'(line == frame_h - 1));
		check_value("m_pixel_first", 32'(m_pixel_first), 32'(x == 0));
		check_value("m_pixel_last", 32'(m_pixel_last), 32'(x == frame_w - 1));
	endtask

	task automatic check_outputs_idle();
		check_value("m_valid", 32'(m_valid), 32'd0);
		check_value("m_line_first", 32'(m_line_first), 32'd0);
		check_value("m_line_last", 32'(m_line_last), 32'd0);
		check_value("m_pixel_first", 32'(m_pixel_first), 32'd0);
		check_value("m_pixel_last", 32'(m_pixel_last), 32'd0);
		check_value("m_de", 32'(m_de), 32'd0);
	endtask

	task automatic drive_pixel(input logic line_first, input logic line_last,
			input logic pixel_first, input logic pixel_last, input logic de, input pixel_t data);
		s_line_first  = line_first;
		s_line_last   = line_last;
		s_pixel_first = pixel_first;
		s_pixel_last  = pixel_last;
		s_de          = de;
		s_valid       = 1'b1;
		s_data        = data;
		@(posedge clk);
		#1;
	endtask

	task automatic drive_idle(input int cycles);
		s_line_first  = 1'b0;
		s_line_last   = 1'b0;
		s_pixel_first = 1'b0;
		s_pixel_last  = 1'b0;
		s_de          = 1'b0;
		s_valid       = 1'b0;
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one frame, two flush lines, then wait for every centre line
	task automatic run_frame(input int width, input int height, input border_mode_t mode,
			input pixel_t value, input logic new_data, input logic gaps);
		int total;
		int y;
		int x;
		pixel_t data;
		frame_w      = width;
		frame_h      = height;
		border_mode  = mode;
		border_value = value;
		count_base   = seen_count;
		total        = width * height;
		if (new_data) begin
			for (y = 0; y < height; y++) begin
				for (x = 0; x < width; x++) begin
					rng_state       = xorshift32(rng_state);
					frame_pix[y][x] = rng_state[7:0];
				end
			end
		end
		for (y = 0; y < height + 2; y++) begin
			for (x = 0; x < width; x++) begin
				rng_state = xorshift32(rng_state);
				data      = (y < height) ? frame_pix[y][x] : rng_state[7:0];
				drive_pixel(y == 0, y == height - 1, x == 0, x == width - 1, y < height, data);
				if (gaps && rng_state[9:8] == 2'd0) begin
					drive_idle(1 + int'(rng_state[11:10]) % 3);
				end
			end
		end
		drive_idle(1);
		while (seen_count - count_base < total) begin
			@(posedge clk);
			#1;
		end
		drive_idle(PIPE_LATENCY + 2);
		check_value("de output count", 32'(seen_count - count_base), 32'(total));
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic check_reset_idle();
		int i;
		for (i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
			check_outputs_idle();
		end
		reset = 1'b0;
		for (i = 0; i < 20; i++) begin
			@(posedge clk);
			#1;
			check_outputs_idle();
		end
	endtask

	task automatic replicate_frame();
		run_frame(8, 6, REPLICATE, 8'h00, 1'b1, 1'b0);
	endtask

	task automatic constant_frame();
		run_frame(8, 6, CONSTANT, 8'hA5, 1'b0, 1'b0);
	endtask

	task automatic reflect_frame();
		run_frame(10, 4, REFLECT_101, 8'h00, 1'b1, 1'b0);
	endtask

	// maximum line width with random gaps in valid
	task automatic gapped_wide_frame();
		run_frame(MAX_LINE_PIXELS, 5, REFLECT_101, 8'h00, 1'b1, 1'b1);
	endtask

	// ------------------------------------------------------------------------
	// monitor and watchdog
	// ------------------------------------------------------------------------
	always @(negedge clk) begin : monitor
		int idx;
		if (m_valid === 1'b1 && m_de === 1'b1) begin
			idx = seen_count - count_base;
			if (idx < frame_w * frame_h) begin
				check_column(idx / frame_w, idx % frame_w);
			end
			seen_count = seen_count + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, expected outputs never arrived", cycle_count);
			$display("Test failures found");
			$fatal(1, "run ended by the cycle limit");
		end
	end

	initial begin
		reset         = 1'b1;
		s_line_first  = 1'b0;
		s_line_last   = 1'b0;
		s_pixel_first = 1'b0;
		s_pixel_last  = 1'b0;
		s_de          = 1'b0;
		s_valid       = 1'b0;
		s_data        = '0;
		border_mode   = REPLICATE;
		border_value  = '0;
		check_reset_idle();
		replicate_frame();
		constant_frame();
		reflect_frame();
		gapped_wide_frame();
		run_finished = 1'b1;
		$display("All tests passed!");
		$finish;
	end

	// run stopped early, e.g. by a failing assertion
	final begin
		if (!run_finished) begin
			$display("Test failures found");
		end
	end

endmodule

`default_nettype wire

/* build.f */
line_buffer_pkg.sv
img_ctrl_if.sv
line_ram.sv
line_store.sv
border_locator.sv
border_mux.sv
line_buffer_top.sv
line_buffer_assertions.sv
tb_line_buffer.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_line_buffer -f build.f -o sim_line_buffer
status=0
./obj_dir/sim_line_buffer > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Test failures found" sim.log; then
	echo "simulation failed"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
